// File: rtl/lc4_pkg.sv
// Shared widths, encodings and pipeline records for the LC4 pipeline; import in RTL and testbench
package lc4_pkg;

   // Datapath and register file sizes
   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NUM_REGS  = 8;

   // First fetch address after reset
   localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

   // Condition codes derived from the writeback value
   localparam logic [2:0] NZP_N = 3'b100;
   localparam logic [2:0] NZP_Z = 3'b010;
   localparam logic [2:0] NZP_P = 3'b001;

   // Top nibble of the instruction word, only the supported classes
   typedef enum logic [3:0] {
      OP_NOP     = 4'd0,
      OP_ARITH   = 4'd1,
      OP_LOGIC   = 4'd5,
      OP_LDR     = 4'd6,
      OP_STR     = 4'd7,
      OP_CONST   = 4'd9,
      OP_HICONST = 4'd13
   } opcode_e;

   // Execute operation; zero is the pass-through used by bubbles and no-ops
   typedef enum logic [3:0] {
      ALU_PASS    = 4'd0,
      ALU_ADD     = 4'd1,
      ALU_MUL     = 4'd2,
      ALU_SUB     = 4'd3,
      ALU_ADDI    = 4'd4,
      ALU_AND     = 4'd5,
      ALU_NOT     = 4'd6,
      ALU_OR      = 4'd7,
      ALU_XOR     = 4'd8,
      ALU_ANDI    = 4'd9,
      ALU_CONST   = 4'd10,
      ALU_HICONST = 4'd11,
      ALU_MEMADDR = 4'd12
   } alu_op_e;

   // Control record, all zero for a bubble
   typedef struct packed {
      logic [REG_SEL_W-1:0] r1sel;
      logic                 r1re;
      logic [REG_SEL_W-1:0] r2sel;
      logic                 r2re;
      logic [REG_SEL_W-1:0] wsel;
      logic                 rf_we;
      logic                 is_load;
      logic                 is_store;
      logic                 nzp_we;
      alu_op_e              alu_op;
   } ctrl_t;

   // Data memory request from the memory stage
   typedef struct packed {
      logic              we;
      logic [WORD_W-1:0] addr;
      logic [WORD_W-1:0] wdata;
   } dmem_req_t;

   // Record of one retired instruction
   typedef struct packed {
      logic                 valid;
      logic [WORD_W-1:0]    pc;
      logic [WORD_W-1:0]    insn;
      logic                 rf_we;
      logic [REG_SEL_W-1:0] rf_wsel;
      logic [WORD_W-1:0]    rf_wdata;
      logic                 nzp_we;
      logic [2:0]           nzp;
   } wb_rec_t;

endpackage

// File: rtl/lc4_decoder.sv
// LC4 instruction decoder; used in the decode stage to turn an instruction into a control record
`timescale 1ns/1ps

module lc4_decoder (
   input  logic [lc4_pkg::WORD_W-1:0] i_insn,
   output lc4_pkg::ctrl_t             o_ctrl
);
   import lc4_pkg::*;

   opcode_e              opcode;
   logic [REG_SEL_W-1:0] rd;
   logic [REG_SEL_W-1:0] rs;
   logic [REG_SEL_W-1:0] rt;

   // Register-writing instruction, destination always rd
   function automatic ctrl_t wr_ctrl(input alu_op_e op, input logic [REG_SEL_W-1:0] dst,
                                     input logic re1, input logic [REG_SEL_W-1:0] sel1,
                                     input logic re2, input logic [REG_SEL_W-1:0] sel2);
      ctrl_t c;
      c        = '0;
      c.r1re   = re1;
      c.r1sel  = re1 ? sel1 : '0;
      c.r2re   = re2;
      c.r2sel  = re2 ? sel2 : '0;
      c.wsel   = dst;
      c.rf_we  = 1'b1;
      // Every register write also updates the condition codes
      c.nzp_we = 1'b1;
      c.alu_op = op;
      return c;
   endfunction

   // Fixed field positions
   assign opcode = opcode_e'(i_insn[15:12]);
   assign rd     = i_insn[11:9];
   assign rs     = i_insn[8:6];
   assign rt     = i_insn[2:0];

   always_comb begin
      o_ctrl = '0;
      case (opcode)
         OP_ARITH: begin
            if (i_insn[5]) begin
               o_ctrl = wr_ctrl(ALU_ADDI, rd, 1'b1, rs, 1'b0, rt);
            end else begin
               case (i_insn[4:3])
                  2'b00:   o_ctrl = wr_ctrl(ALU_ADD, rd, 1'b1, rs, 1'b1, rt);
                  2'b01:   o_ctrl = wr_ctrl(ALU_MUL, rd, 1'b1, rs, 1'b1, rt);
                  2'b10:   o_ctrl = wr_ctrl(ALU_SUB, rd, 1'b1, rs, 1'b1, rt);
                  // Divide not implemented, retires as a no-op
                  default: o_ctrl = '0;
               endcase
            end
         end
         OP_LOGIC: begin
            if (i_insn[5]) begin
               o_ctrl = wr_ctrl(ALU_ANDI, rd, 1'b1, rs, 1'b0, rt);
            end else begin
               case (i_insn[4:3])
                  2'b00:   o_ctrl = wr_ctrl(ALU_AND, rd, 1'b1, rs, 1'b1, rt);
                  2'b01:   o_ctrl = wr_ctrl(ALU_NOT, rd, 1'b1, rs, 1'b0, rt);
                  2'b10:   o_ctrl = wr_ctrl(ALU_OR, rd, 1'b1, rs, 1'b1, rt);
                  default: o_ctrl = wr_ctrl(ALU_XOR, rd, 1'b1, rs, 1'b1, rt);
               endcase
            end
         end
         OP_LDR: begin
            // Address is rs plus IMM6, loaded word goes to rd
            o_ctrl         = wr_ctrl(ALU_MEMADDR, rd, 1'b1, rs, 1'b0, rt);
            o_ctrl.is_load = 1'b1;
         end
         OP_STR: begin
            // Store data register sits in the rd field position
            o_ctrl.r1sel    = rs;
            o_ctrl.r1re     = 1'b1;
            o_ctrl.r2sel    = rd;
            o_ctrl.r2re     = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.alu_op   = ALU_MEMADDR;
         end
         OP_CONST: o_ctrl = wr_ctrl(ALU_CONST, rd, 1'b0, rs, 1'b0, rt);
         OP_HICONST: begin
            // Bit 8 set marks HICONST, which keeps the low byte of rd
            if (i_insn[8]) begin
               o_ctrl = wr_ctrl(ALU_HICONST, rd, 1'b1, rd, 1'b0, rt);
            end
         end
         default: o_ctrl = '0;
      endcase
   end

endmodule

// File: rtl/lc4_regfile.sv
// LC4 register file; read in decode, written from writeback, same-cycle write visible on reads
`timescale 1ns/1ps

module lc4_regfile (
   input  logic                          gwe,
   input  logic                          i_rst,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd_sel,
   input  logic                          i_rd_we,
   input  logic [lc4_pkg::WORD_W-1:0]    i_rd_data,
   output logic [lc4_pkg::WORD_W-1:0]    o_rs_data,
   output logic [lc4_pkg::WORD_W-1:0]    o_rt_data
);
   import lc4_pkg::*;

   // Architectural registers R0..R7
   logic [WORD_W-1:0] regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_rd_data;
      end
   end

   // Write-through, so decode sees the value retiring this cycle
   assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_rd_data : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_rd_data : regs[i_rt_sel];

endmodule

// File: rtl/lc4_alu.sv
// LC4 execute unit; computes register results and load/store addresses in the execute stage
`timescale 1ns/1ps

module lc4_alu (
   input  lc4_pkg::alu_op_e           i_alu_op,
   input  logic [lc4_pkg::WORD_W-1:0] i_insn,
   input  logic [lc4_pkg::WORD_W-1:0] i_pc,
   input  logic [lc4_pkg::WORD_W-1:0] i_rs,
   input  logic [lc4_pkg::WORD_W-1:0] i_rt,
   output logic [lc4_pkg::WORD_W-1:0] o_result
);
   import lc4_pkg::*;

   logic [WORD_W-1:0] imm5;
   logic [WORD_W-1:0] imm6;
   logic [WORD_W-1:0] imm9;
   logic [7:0]        uimm8;

   // Sign-extended immediates
   assign imm5  = {{(WORD_W-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6  = {{(WORD_W-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9  = {{(WORD_W-9){i_insn[8]}}, i_insn[8:0]};
   // Unsigned byte for HICONST
   assign uimm8 = i_insn[7:0];

   always_comb begin
      case (i_alu_op)
         ALU_ADD:     o_result = i_rs + i_rt;
         // Low half of the product only
         ALU_MUL:     o_result = i_rs * i_rt;
         ALU_SUB:     o_result = i_rs - i_rt;
         ALU_ADDI:    o_result = i_rs + imm5;
         ALU_AND:     o_result = i_rs & i_rt;
         ALU_NOT:     o_result = ~i_rs;
         ALU_OR:      o_result = i_rs | i_rt;
         ALU_XOR:     o_result = i_rs ^ i_rt;
         ALU_ANDI:    o_result = i_rs & imm5;
         ALU_CONST:   o_result = imm9;
         // New high byte over the old low byte of rd
         ALU_HICONST: o_result = {uimm8, i_rs[7:0]};
         // Effective address for LDR and STR
         ALU_MEMADDR: o_result = i_rs + imm6;
         // No-ops carry their PC, never written back
         ALU_PASS:    o_result = i_pc;
         default:     o_result = '0;
      endcase
   end

endmodule

// File: rtl/lc4_bypass.sv
// Operand forwarding for the LC4 pipeline; feeds execute operands and memory-stage store data
`timescale 1ns/1ps

module lc4_bypass (
   input  lc4_pkg::ctrl_t             i_x_ctrl,
   input  lc4_pkg::ctrl_t             i_m_ctrl,
   input  lc4_pkg::ctrl_t             i_w_ctrl,
   input  logic [lc4_pkg::WORD_W-1:0] i_x_rs,
   input  logic [lc4_pkg::WORD_W-1:0] i_x_rt,
   input  logic [lc4_pkg::WORD_W-1:0] i_m_alu,
   input  logic [lc4_pkg::WORD_W-1:0] i_m_rt,
   input  logic [lc4_pkg::WORD_W-1:0] i_w_data,
   output logic [lc4_pkg::WORD_W-1:0] o_rs,
   output logic [lc4_pkg::WORD_W-1:0] o_rt,
   output logic [lc4_pkg::WORD_W-1:0] o_store_data
);
   logic m_fwd;
   logic mx_rs;
   logic mx_rt;
   logic wx_rs;
   logic wx_rt;
   logic wm_st;

   // M result is usable only for non-load writers
   assign m_fwd = i_m_ctrl.rf_we && !i_m_ctrl.is_load;

   // MX paths
   assign mx_rs = i_x_ctrl.r1re && m_fwd && (i_x_ctrl.r1sel == i_m_ctrl.wsel);
   assign mx_rt = i_x_ctrl.r2re && m_fwd && (i_x_ctrl.r2sel == i_m_ctrl.wsel);

   // WX paths, lower priority than MX
   assign wx_rs = i_x_ctrl.r1re && i_w_ctrl.rf_we && (i_x_ctrl.r1sel == i_w_ctrl.wsel);
   assign wx_rt = i_x_ctrl.r2re && i_w_ctrl.rf_we && (i_x_ctrl.r2sel == i_w_ctrl.wsel);

   // WM path, load directly followed by a store of the loaded register
   assign wm_st = i_m_ctrl.is_store && i_w_ctrl.is_load && (i_m_ctrl.r2sel == i_w_ctrl.wsel);

   assign o_rs         = mx_rs ? i_m_alu : (wx_rs ? i_w_data : i_x_rs);
   assign o_rt         = mx_rt ? i_m_alu : (wx_rt ? i_w_data : i_x_rt);
   assign o_store_data = wm_st ? i_w_data : i_m_rt;

endmodule

// File: rtl/lc4_processor.sv
// Five-stage LC4 pipeline top; attach instruction and data memories and observe retirement on o_wb
`timescale 1ns/1ps

module lc4_processor (
   input  logic                       gwe,
   input  logic                       i_rst,
   output logic [lc4_pkg::WORD_W-1:0] o_cur_pc,
   input  logic [lc4_pkg::WORD_W-1:0] i_cur_insn,
   output lc4_pkg::dmem_req_t         o_dmem,
   input  logic [lc4_pkg::WORD_W-1:0] i_dmem_rdata,
   output lc4_pkg::wb_rec_t           o_wb
);
   import lc4_pkg::*;

   // Fetch to decode
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] pc;
      logic [WORD_W-1:0] insn;
   } d_reg_t;

   // Decode to execute, operands as read from the register file
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] pc;
      logic [WORD_W-1:0] insn;
      ctrl_t             ctrl;
      logic [WORD_W-1:0] rs;
      logic [WORD_W-1:0] rt;
   } x_reg_t;

   // Execute to memory, rt already forwarded
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] pc;
      logic [WORD_W-1:0] insn;
      ctrl_t             ctrl;
      logic [WORD_W-1:0] alu;
      logic [WORD_W-1:0] rt;
   } m_reg_t;

   // Memory to writeback
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] pc;
      logic [WORD_W-1:0] insn;
      ctrl_t             ctrl;
      logic [WORD_W-1:0] alu;
      logic [WORD_W-1:0] ldata;
   } w_reg_t;

   logic [WORD_W-1:0] pc_q;
   d_reg_t            d_q;
   x_reg_t            x_q;
   m_reg_t            m_q;
   w_reg_t            w_q;
   ctrl_t             d_ctrl;
   logic [WORD_W-1:0] d_rs;
   logic [WORD_W-1:0] d_rt;
   logic [WORD_W-1:0] x_rs;
   logic [WORD_W-1:0] x_rt;
   logic [WORD_W-1:0] x_alu;
   logic [WORD_W-1:0] m_store_data;
   logic [WORD_W-1:0] w_data;
   logic [2:0]        w_nzp;

   // PC never redirects, steps by one every cycle
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= pc_q + WORD_W'(1);
      end
   end

   assign o_cur_pc = pc_q;

   // Decode and register read, W stage writes back here
   lc4_decoder u_decoder (
      .i_insn (d_q.insn),
      .o_ctrl (d_ctrl)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_rs_sel  (d_ctrl.r1sel),
      .i_rt_sel  (d_ctrl.r2sel),
      .i_rd_sel  (w_q.ctrl.wsel),
      .i_rd_we   (w_q.ctrl.rf_we),
      .i_rd_data (w_data),
      .o_rs_data (d_rs),
      .o_rt_data (d_rt)
   );

   // Execute with forwarded operands
   lc4_bypass u_bypass (
      .i_x_ctrl     (x_q.ctrl),
      .i_m_ctrl     (m_q.ctrl),
      .i_w_ctrl     (w_q.ctrl),
      .i_x_rs       (x_q.rs),
      .i_x_rt       (x_q.rt),
      .i_m_alu      (m_q.alu),
      .i_m_rt       (m_q.rt),
      .i_w_data     (w_data),
      .o_rs         (x_rs),
      .o_rt         (x_rt),
      .o_store_data (m_store_data)
   );

   lc4_alu u_alu (
      .i_alu_op (x_q.ctrl.alu_op),
      .i_insn   (x_q.insn),
      .i_pc     (x_q.pc),
      .i_rs     (x_rs),
      .i_rt     (x_rt),
      .o_result (x_alu)
   );

   // Memory port, address and data zeroed when unused
   always_comb begin
      o_dmem.we    = m_q.ctrl.is_store;
      o_dmem.addr  = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? m_q.alu : '0;
      o_dmem.wdata = m_q.ctrl.is_store ? m_store_data : '0;
   end

   // Writeback value and its condition codes
   assign w_data = w_q.ctrl.is_load ? w_q.ldata : w_q.alu;
   assign w_nzp  = w_data[WORD_W-1] ? NZP_N : ((w_data == '0) ? NZP_Z : NZP_P);

   always_comb begin
      o_wb.valid    = w_q.valid;
      o_wb.pc       = w_q.pc;
      o_wb.insn     = w_q.insn;
      o_wb.rf_we    = w_q.ctrl.rf_we;
      o_wb.rf_wsel  = w_q.ctrl.wsel;
      o_wb.rf_wdata = w_data;
      o_wb.nzp_we   = w_q.ctrl.nzp_we;
      o_wb.nzp      = w_nzp;
   end

   // Pipeline registers advance every edge
   always_ff @(posedge gwe) begin
      d_q <= '{valid: 1'b1, pc: pc_q, insn: i_cur_insn};
      x_q <= '{valid: d_q.valid, pc: d_q.pc, insn: d_q.insn, ctrl: d_ctrl,
               rs: d_rs, rt: d_rt};
      m_q <= '{valid: x_q.valid, pc: x_q.pc, insn: x_q.insn, ctrl: x_q.ctrl,
               alu: x_alu, rt: x_rt};
      w_q <= '{valid: m_q.valid, pc: m_q.pc, insn: m_q.insn, ctrl: m_q.ctrl,
               alu: m_q.alu, ldata: i_dmem_rdata};
      // Reset turns every stage into a bubble
      if (i_rst) begin
         d_q.valid <= 1'b0;
         d_q.insn  <= '0;
         x_q.valid <= 1'b0;
         x_q.ctrl  <= '0;
         m_q.valid <= 1'b0;
         m_q.ctrl  <= '0;
         w_q.valid <= 1'b0;
         w_q.ctrl  <= '0;
      end
   end

endmodule

// File: dv/lc4_tb.sv
// Self-checking testbench for the LC4 pipeline; runs a fixed program and checks every retirement
`timescale 1ns/1ps

module lc4_tb;
   import lc4_pkg::*;

   localparam int PROG_LEN    = 28;
   localparam int IMEM_DEPTH  = 64;
   localparam int WAIT_CYCLES = 10;
   localparam int DRIVE_DLY   = 2;

   logic              gwe;
   logic              i_rst;
   logic [WORD_W-1:0] cur_pc;
   logic [WORD_W-1:0] cur_insn;
   logic [WORD_W-1:0] pc_off;
   dmem_req_t         dmem_out;
   logic [WORD_W-1:0] dmem_rdata;
   wb_rec_t           wb_out;

   logic [WORD_W-1:0] program_tbl [PROG_LEN];
   logic [WORD_W-1:0] imem [IMEM_DEPTH];
   logic [WORD_W-1:0] dmem [65536];
   // Model's own copy of data memory
   logic [WORD_W-1:0] ref_mem [65536];
   wb_rec_t           exp_wb_q [$];
   dmem_req_t         exp_dmem_q [$];
   // Memory port as seen one cycle before the current record
   dmem_req_t         last_dmem;
   int                wb_errors;
   int                dmem_errors;
   int                misc_errors;
   int                checked;
   bit                timed_out;

   lc4_processor DUT (
      .gwe          (gwe),
      .i_rst        (i_rst),
      .o_cur_pc     (cur_pc),
      .i_cur_insn   (cur_insn),
      .o_dmem       (dmem_out),
      .i_dmem_rdata (dmem_rdata),
      .o_wb         (wb_out)
   );

   // Instruction memory that reads as opcode 0 past the program
   assign pc_off   = cur_pc - RESET_PC;
   assign cur_insn = (pc_off < 16'(IMEM_DEPTH)) ? imem[pc_off[5:0]] : '0;

   // Data memory with combinational read and write at the edge
   assign dmem_rdata = dmem[dmem_out.addr];

   always @(posedge gwe) begin
      if (dmem_out.we === 1'b1) begin
         dmem[dmem_out.addr] <= dmem_out.wdata;
      end
   end

   // 20 ns clock
   initial begin
      gwe = 1'b0;
      forever begin
         #10 gwe = ~gwe;
      end
   end

   // Condition code of a written value
   function automatic logic [2:0] sign_code(input logic [WORD_W-1:0] v);
      if (v[WORD_W-1]) begin
         return 3'b100;
      end else if (v == '0) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

   // Returns one on a mismatch and logs it
   function automatic int compare_field(input string name, input logic [WORD_W-1:0] got,
                                        input logic [WORD_W-1:0] exp,
                                        input logic [WORD_W-1:0] pc);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h expected 0x%h at pc 0x%h", name, got, exp, pc);
         return 1;
      end
      return 0;
   endfunction

   task automatic check_wb(input wb_rec_t got, input wb_rec_t exp);
      wb_errors += compare_field("o_wb.pc", got.pc, exp.pc, exp.pc);
      wb_errors += compare_field("o_wb.insn", got.insn, exp.insn, exp.pc);
      wb_errors += compare_field("o_wb.rf_we", WORD_W'(got.rf_we), WORD_W'(exp.rf_we), exp.pc);
      wb_errors += compare_field("o_wb.nzp_we", WORD_W'(got.nzp_we), WORD_W'(exp.nzp_we),
                                 exp.pc);
      // Destination, data and codes only mean something on a register write
      if (exp.rf_we) begin
         wb_errors += compare_field("o_wb.rf_wsel", WORD_W'(got.rf_wsel), WORD_W'(exp.rf_wsel),
                                    exp.pc);
         wb_errors += compare_field("o_wb.rf_wdata", got.rf_wdata, exp.rf_wdata, exp.pc);
         wb_errors += compare_field("o_wb.nzp", WORD_W'(got.nzp), WORD_W'(exp.nzp), exp.pc);
      end
   endtask

   task automatic check_dmem(input dmem_req_t got, input dmem_req_t exp,
                             input logic [WORD_W-1:0] pc);
      dmem_errors += compare_field("o_dmem.we", WORD_W'(got.we), WORD_W'(exp.we), pc);
      dmem_errors += compare_field("o_dmem.addr", got.addr, exp.addr, pc);
      dmem_errors += compare_field("o_dmem.wdata", got.wdata, exp.wdata, pc);
   endtask

   // Step negedge by negedge to the next valid record and flag stray writes meanwhile
   task automatic wait_record(output bit found);
      int cycles;
      found  = 1'b0;
      cycles = 0;
      while (!found && cycles < WAIT_CYCLES) begin
         last_dmem = dmem_out;
         @(negedge gwe);
         cycles++;
         if (wb_out.valid === 1'b1) begin
            found = 1'b1;
         end else begin
            if (wb_out.rf_we !== 1'b0 || wb_out.nzp_we !== 1'b0) begin
               $display("Register write seen while no instruction retired");
               misc_errors++;
            end
            // Nothing real was in the memory stage one cycle before an empty writeback
            if (last_dmem.we !== 1'b0) begin
               $display("Memory write seen with no instruction in the memory stage");
               misc_errors++;
            end
         end
      end
   endtask

   // In-order ISA model over the program table
   task automatic run_model();
      logic [WORD_W-1:0]    regs [NUM_REGS];
      logic [WORD_W-1:0]    insn;
      logic [WORD_W-1:0]    val;
      logic [WORD_W-1:0]    imm5;
      logic [WORD_W-1:0]    imm6;
      logic [WORD_W-1:0]    imm9;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic [REG_SEL_W-1:0] rt;
      logic                 wr;
      wb_rec_t              wb;
      dmem_req_t            dm;
      regs = '{default: '0};
      for (int k = 0; k < PROG_LEN; k++) begin
         insn = program_tbl[5'(k)];
         rd   = insn[11:9];
         rs   = insn[8:6];
         rt   = insn[2:0];
         imm5 = {{11{insn[4]}}, insn[4:0]};
         imm6 = {{10{insn[5]}}, insn[5:0]};
         imm9 = {{7{insn[8]}}, insn[8:0]};
         wr   = 1'b0;
         val  = '0;
         dm   = '0;
         case (insn[15:12])
            // Arithmetic where sub-op 3 is divide and writes nothing
            4'd1: begin
               wr = 1'b1;
               case (insn[5:3])
                  3'b000:  val = regs[rs] + regs[rt];
                  3'b001:  val = regs[rs] * regs[rt];
                  3'b010:  val = regs[rs] - regs[rt];
                  3'b011:  wr = 1'b0;
                  default: val = regs[rs] + imm5;
               endcase
            end
            // Logic
            4'd5: begin
               wr = 1'b1;
               case (insn[5:3])
                  3'b000:  val = regs[rs] & regs[rt];
                  3'b001:  val = ~regs[rs];
                  3'b010:  val = regs[rs] | regs[rt];
                  3'b011:  val = regs[rs] ^ regs[rt];
                  default: val = regs[rs] & imm5;
               endcase
            end
            // LDR
            4'd6: begin
               dm.addr = regs[rs] + imm6;
               val     = ref_mem[dm.addr];
               wr      = 1'b1;
            end
            // STR with the data register in the rd field
            4'd7: begin
               dm.we            = 1'b1;
               dm.addr          = regs[rs] + imm6;
               dm.wdata         = regs[rd];
               ref_mem[dm.addr] = regs[rd];
            end
            4'd9: begin
               val = imm9;
               wr  = 1'b1;
            end
            // HICONST only with bit 8 set
            4'd13: begin
               if (insn[8]) begin
                  val = {insn[7:0], regs[rd][7:0]};
                  wr  = 1'b1;
               end
            end
            default: wr = 1'b0;
         endcase
         wb        = '0;
         wb.valid  = 1'b1;
         wb.pc     = RESET_PC + WORD_W'(k);
         wb.insn   = insn;
         wb.rf_we  = wr;
         wb.nzp_we = wr;
         if (wr) begin
            wb.rf_wsel  = rd;
            wb.rf_wdata = val;
            wb.nzp      = sign_code(val);
            regs[rd]    = val;
         end
         exp_wb_q.push_back(wb);
         exp_dmem_q.push_back(dm);
      end
   endtask

   initial begin
      logic [WORD_W-1:0] v;
      wb_rec_t           exp_wb;
      dmem_req_t         exp_dmem;
      bit                found;
      i_rst = 1'b1;
      void'($urandom(32'ha71d8ae1));
      for (int a = 0; a < 65536; a++) begin
         v                = WORD_W'($urandom);
         ref_mem[16'(a)]  = v;
         dmem[16'(a)]    <= v;
      end
      // Distances of one, two and three between dependent instructions
      program_tbl = '{16'h9205,   // CONST   R1, #5
                      16'h95FD,   // CONST   R2, #-3
                      16'h1642,   // ADD     R3, R1, R2
                      16'h18C9,   // MUL     R4, R3, R1
                      16'h1B13,   // SUB     R5, R4, R3
                      16'h1D79,   // ADDI    R5 -7 into R6
                      16'h5F84,   // AND     R7, R6, R4
                      16'h53C8,   // NOT     R1, R7
                      16'h5455,   // OR      R2, R1, R5
                      16'h569E,   // XOR     R3, R2, R6
                      16'h58EF,   // ANDI    R4, R3, #15
                      16'h9C40,   // CONST   R6, #64
                      16'hDD01,   // HICONST R6, #1
                      16'h6182,   // LDR     R0, R6, #2
                      16'h7185,   // STR     R0, R6, #5 via WM
                      16'h6385,   // LDR     R1, R6, #5 reads back
                      16'h94A3,   // CONST   R2, #163
                      16'h1642,   // ADD     R3, R1, R2
                      16'h77BF,   // STR     R3, R6, #-1
                      16'h0000,   // Opcode 0
                      16'h129B,   // Unsupported DIV
                      16'hA123,   // Unsupported shift
                      16'hF025,   // Unsupported TRAP
                      16'h69BF,   // LDR     R4, R6, #-1
                      16'h6F8A,   // LDR     R7, R6, #10
                      16'h7F8B,   // STR     R7, R6, #11 via WM
                      16'h1B20,   // ADDI    R5, R4, #0
                      16'h9000};  // CONST   R0, #0
      imem = '{default: '0};
      for (int i = 0; i < PROG_LEN; i++) begin
         imem[6'(i)] = program_tbl[5'(i)];
      end
      run_model();
      repeat (4) @(posedge gwe);
      #DRIVE_DLY i_rst = 1'b0;
      @(negedge gwe);
      for (int k = 0; k < PROG_LEN && !timed_out; k++) begin
         wait_record(found);
         if (!found) begin
            $display("Timeout waiting for the writeback of instruction %0d", k);
            misc_errors++;
            timed_out = 1'b1;
         end else begin
            exp_wb   = exp_wb_q.pop_front();
            exp_dmem = exp_dmem_q.pop_front();
            check_wb(wb_out, exp_wb);
            check_dmem(last_dmem, exp_dmem, exp_wb.pc);
            checked++;
         end
      end
      $display("Checked %0d records: %0d wb errors, %0d dmem errors, %0d other errors",
               checked, wb_errors, dmem_errors, misc_errors);
      if (timed_out || (wb_errors + dmem_errors + misc_errors) != 0) begin
         $display("ERRORS FOUND");
      end else begin
         $display("NO ERRORS");
      end
      $finish;
   end

endmodule

// File: sources.f
rtl/lc4_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_alu.sv
rtl/lc4_bypass.sv
rtl/lc4_processor.sv
dv/lc4_tb.sv

// File: Makefile
# Verilator build and run of the LC4 pipeline testbench

BIN := obj_dir/Vlc4_tb

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(BIN): sources.f $(wildcard rtl/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing -j 0 --top-module lc4_tb -f sources.f -o Vlc4_tb

# The log decides pass or fail
run: $(BIN)
	$(BIN) | tee sim.log
	@grep -qx "NO ERRORS" sim.log || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
